/* rtl/astro_sys_pkg.sv */
//====================
// Astrocade board constants
// Game ids, loader indices and
// data widths shared by the I/O block
//====================
package astro_sys_pkg;

	// Game ids as written by the ROM loader
	localparam int unsigned GAME_W = 8;
	localparam logic [GAME_W-1:0] GAME_SPACEZAP = 8'd3;
	localparam logic [GAME_W-1:0] GAME_GORF     = 8'd4;
	localparam logic [GAME_W-1:0] GAME_WOW      = 8'd5;
	localparam logic [GAME_W-1:0] GAME_ROBBY    = 8'd6;

	// Loader side
	localparam logic [7:0] IDX_GAME = 8'd1;    // Game id write
	localparam logic [7:0] IDX_DIP  = 8'd254;  // DIP bank write
	localparam int unsigned DIP_BYTES = 8;
	localparam int unsigned DIP_AW    = $clog2(DIP_BYTES);
	localparam int unsigned LD_ADDR_W = 25;
	localparam int unsigned LD_DATA_W = 16;    // Only low byte used

	// Audio
	localparam int unsigned SND_W = 8;         // Sound chip output
	localparam int unsigned AUD_W = 16;        // Board output and speech
	// Speech is much louder than the sound chip
	localparam int unsigned SAMPLE_SHIFT = 3;

endpackage

/* rtl/astro_input_pkg.sv */
//====================
// Astrocade input codes
// PS/2 scan codes, joystick bits and
// switch matrix column strobes
//====================
package astro_input_pkg;

	// Player 1, cursor keys come with E0 prefix
	localparam logic [8:0] KEY_UP     = 9'h075;
	localparam logic [8:0] KEY_DOWN   = 9'h072;
	localparam logic [8:0] KEY_LEFT   = 9'h06B;
	localparam logic [8:0] KEY_RIGHT  = 9'h074;
	localparam logic [8:0] KEY_FIRE1  = 9'h014;  // Ctrl
	localparam logic [8:0] KEY_FIRE2  = 9'h029;  // Space

	// System keys, function row and MAME style
	localparam logic [8:0] KEY_START1_F = 9'h005;  // F1
	localparam logic [8:0] KEY_START2_F = 9'h006;  // F2
	localparam logic [8:0] KEY_COIN_F   = 9'h004;  // F3
	localparam logic [8:0] KEY_START1   = 9'h016;  // 1
	localparam logic [8:0] KEY_START2   = 9'h01E;  // 2
	localparam logic [8:0] KEY_COIN     = 9'h02E;  // 5

	// Player 2
	localparam logic [8:0] KEY_UP2     = 9'h02D;  // R
	localparam logic [8:0] KEY_DOWN2   = 9'h02B;  // F
	localparam logic [8:0] KEY_LEFT2   = 9'h023;  // D
	localparam logic [8:0] KEY_RIGHT2  = 9'h034;  // G
	localparam logic [8:0] KEY_FIRE1_2 = 9'h01C;  // A
	localparam logic [8:0] KEY_FIRE2_2 = 9'h01B;  // S

	// Bit positions in the 16-bit joystick word
	localparam int unsigned JOY_RIGHT  = 0;
	localparam int unsigned JOY_LEFT   = 1;
	localparam int unsigned JOY_DOWN   = 2;
	localparam int unsigned JOY_UP     = 3;
	localparam int unsigned JOY_FIRE   = 4;
	localparam int unsigned JOY_FIRE_B = 5;
	localparam int unsigned JOY_START1 = 6;
	localparam int unsigned JOY_START2 = 7;
	localparam int unsigned JOY_COIN   = 8;

	// Column strobes from the CPU
	localparam logic [7:0] COL_CT0 = 8'h01;
	localparam logic [7:0] COL_CT1 = 8'h02;
	localparam logic [7:0] COL_CT2 = 8'h04;
	localparam logic [7:0] COL_CT3 = 8'h08;
	localparam logic [7:0] ROW_IDLE = 8'hFF;  // Nothing pressed

endpackage

/* rtl/game_config.sv */
//====================
// Game configuration
// Captures game id and DIP bank from
// the ROM loader, decodes game flags
//====================
`timescale 1ns/1ps

module game_config
	import astro_sys_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ld_wr,     // One-cycle strobe
	input  logic [7:0]           ld_index,
	input  logic [LD_ADDR_W-1:0] ld_addr,
	input  logic [LD_DATA_W-1:0] ld_dout,
	output logic                 is_spacezap,
	output logic                 is_gorf,
	output logic                 is_wow,
	output logic                 is_robby,
	output logic [7:0]           dip2,
	output logic [7:0]           dip3
);

	logic [GAME_W-1:0] game_id;
	logic [7:0]        dip_bank [DIP_BYTES];

	wire game_wr = ld_wr && (ld_index == IDX_GAME);
	wire dip_wr  = ld_wr && (ld_index == IDX_DIP) && (ld_addr < DIP_BYTES);

	// Loader writes
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_id <= '0;
			for (int i = 0; i < DIP_BYTES; i++)
				dip_bank[i] <= 8'h00;
		end else begin
			if (game_wr)
				game_id <= ld_dout[GAME_W-1:0];
			if (dip_wr)
				dip_bank[ld_addr[DIP_AW-1:0]] <= ld_dout[7:0];  // Low byte only
		end
	end

	// Flags lag the id by one edge
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			is_spacezap <= 1'b0;
			is_gorf     <= 1'b0;
			is_wow      <= 1'b0;
			is_robby    <= 1'b0;
		end else begin
			is_spacezap <= (game_id == GAME_SPACEZAP);
			is_gorf     <= (game_id == GAME_GORF);
			is_wow      <= (game_id == GAME_WOW);
			is_robby    <= (game_id == GAME_ROBBY);  // Unknown id leaves all low
		end
	end

	assign dip2 = dip_bank[2];
	assign dip3 = dip_bank[3];

	// Downstream muxes assume one game at a time
	a_flags_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0({is_spacezap, is_gorf, is_wow, is_robby}));

endmodule

/* rtl/player_controls.sv */
//====================
// Player controls
// Latches PS/2 key events per button
// and merges them with two joysticks
//====================
`timescale 1ns/1ps

module player_controls
	import astro_input_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key,  // Toggle, pressed, code
	input  logic [15:0] joy0,
	input  logic [15:0] joy1,
	output logic        p1_up,
	output logic        p1_down,
	output logic        p1_left,
	output logic        p1_right,
	output logic        p1_fire,
	output logic        p1_fire_b,
	output logic        p2_up,
	output logic        p2_down,
	output logic        p2_left,
	output logic        p2_right,
	output logic        p2_fire,
	output logic        p2_fire_b,
	output logic        start1,
	output logic        start2,
	output logic        coin
);

	logic       toggle_q;  // Last seen toggle
	wire        pressed   = ps2_key[9];
	wire  [8:0] code      = ps2_key[8:0];
	wire        key_event = (ps2_key[10] != toggle_q);

	// Key latches
	logic k_up, k_down, k_left, k_right, k_fire1, k_fire2;
	logic k_start1_f, k_start2_f, k_coin_f, k_start1, k_start2, k_coin;
	logic k_up2, k_down2, k_left2, k_right2, k_fire1_2, k_fire2_2;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q <= 1'b0;
			{k_up, k_down, k_left, k_right, k_fire1, k_fire2} <= '0;
			{k_start1_f, k_start2_f, k_coin_f, k_start1, k_start2, k_coin} <= '0;
			{k_up2, k_down2, k_left2, k_right2, k_fire1_2, k_fire2_2} <= '0;
		end else begin
			toggle_q <= ps2_key[10];
			if (key_event) begin
				case (code)
					// Cursor keys, E0 prefix or not
					KEY_UP,    KEY_UP | 9'h100:    k_up    <= pressed;
					KEY_DOWN,  KEY_DOWN | 9'h100:  k_down  <= pressed;
					KEY_LEFT,  KEY_LEFT | 9'h100:  k_left  <= pressed;
					KEY_RIGHT, KEY_RIGHT | 9'h100: k_right <= pressed;
					KEY_FIRE1:    k_fire1    <= pressed;
					KEY_FIRE2:    k_fire2    <= pressed;
					KEY_START1_F: k_start1_f <= pressed;
					KEY_START2_F: k_start2_f <= pressed;
					KEY_COIN_F:   k_coin_f   <= pressed;
					KEY_START1:   k_start1   <= pressed;
					KEY_START2:   k_start2   <= pressed;
					KEY_COIN:     k_coin     <= pressed;
					KEY_UP2:      k_up2      <= pressed;
					KEY_DOWN2:    k_down2    <= pressed;
					KEY_LEFT2:    k_left2    <= pressed;
					KEY_RIGHT2:   k_right2   <= pressed;
					KEY_FIRE1_2:  k_fire1_2  <= pressed;
					KEY_FIRE2_2:  k_fire2_2  <= pressed;
					default: ;  // Other keys ignored
				endcase
			end
		end
	end

	// System buttons come from joy0 only
	assign start1 = k_start1_f | k_start1 | joy0[JOY_START1];
	assign start2 = k_start2_f | k_start2 | joy0[JOY_START2];
	assign coin   = k_coin_f | k_coin | joy0[JOY_COIN];

	assign p1_up     = k_up    | joy0[JOY_UP];
	assign p1_down   = k_down  | joy0[JOY_DOWN];
	assign p1_left   = k_left  | joy0[JOY_LEFT];
	assign p1_right  = k_right | joy0[JOY_RIGHT];
	assign p1_fire   = k_fire1 | joy0[JOY_FIRE];
	assign p1_fire_b = k_fire2 | joy0[JOY_FIRE_B];

	assign p2_up     = k_up2     | joy1[JOY_UP];
	assign p2_down   = k_down2   | joy1[JOY_DOWN];
	assign p2_left   = k_left2   | joy1[JOY_LEFT];
	assign p2_right  = k_right2  | joy1[JOY_RIGHT];
	assign p2_fire   = k_fire1_2 | joy1[JOY_FIRE];
	assign p2_fire_b = k_fire2_2 | joy1[JOY_FIRE_B];

	// An X toggle would fire phantom events
	a_toggle_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown(ps2_key[10]));

endmodule

/* rtl/switch_matrix.sv */
//====================
// Switch matrix
// Row byte for the strobed column,
// laid out per game, active low
//====================
`timescale 1ns/1ps

module switch_matrix
	import astro_input_pkg::*;
(
	input  logic [7:0] col_select,
	input  logic       speech_busy,  // Votrax status
	input  logic       is_spacezap,
	input  logic       is_gorf,
	input  logic       is_wow,
	input  logic       is_robby,
	input  logic [7:0] dip2,
	input  logic [7:0] dip3,
	input  logic       p1_up, p1_down, p1_left, p1_right, p1_fire, p1_fire_b,
	input  logic       p2_up, p2_down, p2_left, p2_right, p2_fire, p2_fire_b,
	input  logic       start1,
	input  logic       start2,
	input  logic       coin,
	output logic [7:0] row_data
);

	// Directions R, L, D, U in the low nibble
	wire [3:0] p1_dir_n = ~{p1_right, p1_left, p1_down, p1_up};
	wire [3:0] p2_dir_n = ~{p2_right, p2_left, p2_down, p2_up};
	wire       no_game  = ~(is_spacezap | is_gorf | is_wow | is_robby);

	//====================
	// Column 1, system
	wire [7:0] ct0_sz = {2'b11, ~start2, ~start1, dip2[1], 1'b1, ~coin, 1'b1};
	wire [7:0] ct0_gf = {dip2[2], dip2[0], ~start2, ~start1, 1'b1, dip2[1], ~coin, 1'b1};
	wire [7:0] ct0_ww = {dip2[2], ~start2, ~start1, 1'b1, dip2[1], 1'b1, ~coin, 1'b1};
	wire [7:0] ct0_rr = {1'b0, ~start2, ~start1, 1'b1, dip2[1], 1'b1, ~coin, 1'b1};

	//====================
	// Column 2, player 2
	wire [7:0] ct1_sz = {3'b111, ~p2_fire, p2_dir_n};
	wire [7:0] ct1_gf = {3'b001, ~p2_fire, p2_dir_n};
	wire [7:0] ct1_ww = {2'b11, ~p2_fire, p2_fire_b, p2_dir_n};  // Fire B active high
	wire [7:0] ct1_rr = {2'b11, ~p2_fire, 1'b1, p2_dir_n};

	//====================
	// Column 4, player 1
	wire [7:0] ct2_sz = {2'b11, dip2[0], ~p1_fire, p1_dir_n};
	wire [7:0] ct2_gf = {speech_busy, 2'b01, ~p1_fire, p1_dir_n};
	wire [7:0] ct2_ww = {speech_busy, 1'b1, ~p1_fire, p1_fire_b, p1_dir_n};
	wire [7:0] ct2_rr = {2'b11, ~p1_fire, 1'b1, p1_dir_n};

	// AND-OR select, flags are one-hot, idle row with no game
	function automatic logic [7:0] by_game(input logic [7:0] sz, input logic [7:0] gf,
			input logic [7:0] ww, input logic [7:0] rr);
		return ({8{is_spacezap}} & sz) | ({8{is_gorf}} & gf) | ({8{is_wow}} & ww) |
			({8{is_robby}} & rr) | ({8{no_game}} & ROW_IDLE);
	endfunction

	always_comb begin
		case (col_select)
			COL_CT0: row_data = by_game(ct0_sz, ct0_gf, ct0_ww, ct0_rr);
			COL_CT1: row_data = by_game(ct1_sz, ct1_gf, ct1_ww, ct1_rr);
			COL_CT2: row_data = by_game(ct2_sz, ct2_gf, ct2_ww, ct2_rr);
			COL_CT3: row_data = dip3;  // DIP bank for all games
			default: row_data = ROW_IDLE;
		endcase
	end

endmodule

/* rtl/audio_mixer.sv */
//====================
// Audio mixer
// Sound chip plus speech samples
// into two registered 16-bit channels
//====================
`timescale 1ns/1ps

module audio_mixer
	import astro_sys_pkg::*;
(
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             is_gorf,
	input  logic             is_wow,
	input  logic             is_robby,
	input  logic [SND_W-1:0] snd_l,
	input  logic [SND_W-1:0] snd_r,
	input  logic [AUD_W-1:0] samp_l,  // Speech
	input  logic [AUD_W-1:0] samp_r,
	output logic [AUD_W-1:0] audio_l,
	output logic [AUD_W-1:0] audio_r
);

	// Gorf: sound chip scaled near half range, speech turned down
	wire [AUD_W-1:0] sum_l = {1'b0, snd_l, snd_l[SND_W-1:1]} + (samp_l >> SAMPLE_SHIFT);
	wire [AUD_W-1:0] sum_r = {1'b0, snd_r, snd_r[SND_W-1:1]} + (samp_r >> SAMPLE_SHIFT);
	wire             stereo = is_wow | is_robby;  // Second sound chip fitted

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else if (is_gorf) begin
			audio_l <= sum_l;
			audio_r <= sum_r;
		end else begin
			audio_l <= {snd_l, snd_l};
			audio_r <= stereo ? {snd_r, snd_r} : {snd_l, snd_l};  // Mono boards copy left
		end
	end

	a_audio_known: assert property (@(posedge clk_sys) disable iff (reset)
		!$isunknown({audio_l, audio_r}));

endmodule

/* rtl/astro_io_top.sv */
//====================
// Astrocade I/O block
// Game config, player controls,
// switch matrix and audio mixer
//====================
`timescale 1ns/1ps

module astro_io_top
	import astro_sys_pkg::*;
(
	input  logic                 clk_sys,
	input  logic                 reset,
	// ROM loader
	input  logic                 ld_wr,
	input  logic [7:0]           ld_index,
	input  logic [LD_ADDR_W-1:0] ld_addr,
	input  logic [LD_DATA_W-1:0] ld_dout,
	// Keyboard and joysticks
	input  logic [10:0]          ps2_key,
	input  logic [15:0]          joy0,
	input  logic [15:0]          joy1,
	// CPU switch matrix
	input  logic [7:0]           col_select,
	input  logic                 speech_busy,
	output logic [7:0]           row_data,
	// Sound
	input  logic [SND_W-1:0]     snd_l,
	input  logic [SND_W-1:0]     snd_r,
	input  logic [AUD_W-1:0]     samp_l,
	input  logic [AUD_W-1:0]     samp_r,
	output logic [AUD_W-1:0]     audio_l,
	output logic [AUD_W-1:0]     audio_r
);

	logic       is_spacezap, is_gorf, is_wow, is_robby;
	logic [7:0] dip2, dip3;
	logic       p1_up, p1_down, p1_left, p1_right, p1_fire, p1_fire_b;
	logic       p2_up, p2_down, p2_left, p2_right, p2_fire, p2_fire_b;
	logic       start1, start2, coin;

	// Ports share names, connect by name
	game_config     u_game_config (.*);
	player_controls u_player_controls (.*);
	switch_matrix   u_switch_matrix (.*);
	audio_mixer     u_audio_mixer (.*);

endmodule

/* dv/tb_clock.sv */
//====================
// Testbench clock and reset
// 20 ns clk_sys, reset held 2 cycles
//====================
`timescale 1ns/1ps

module tb_clock (
	output logic clk_sys,
	output logic reset
);

	localparam time HALF_PERIOD = 10ns;

	initial begin
		clk_sys = 1'b0;
		reset   = 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;  // Released on a falling edge
	end

	always #(HALF_PERIOD) clk_sys = ~clk_sys;

endmodule

/* dv/tb_astro_io.sv */
//====================
// Testbench for the I/O block
// Directed tests on game select, keys,
// joysticks, DIP bank and audio
//====================
`timescale 1ns/1ps

module tb_astro_io
	import astro_sys_pkg::*, astro_input_pkg::*;
();

	localparam int unsigned TIMEOUT_CYCLES = 2000;  // Well above the test length

	logic                 clk_sys, reset;
	logic                 ld_wr;
	logic [7:0]           ld_index;
	logic [LD_ADDR_W-1:0] ld_addr;
	logic [LD_DATA_W-1:0] ld_dout;
	logic [10:0]          ps2_key;
	logic [15:0]          joy0, joy1;
	logic [7:0]           col_select;
	logic                 speech_busy;
	logic [7:0]           row_data;
	logic [SND_W-1:0]     snd_l, snd_r;
	logic [AUD_W-1:0]     samp_l, samp_r;
	logic [AUD_W-1:0]     audio_l, audio_r;

	int          errors;
	int          checks;
	int unsigned cycles = 0;
	logic        tog;       // PS/2 event toggle
	logic [31:0] rng;

	tb_clock u_clock (.clk_sys, .reset);
	astro_io_top UUT (.*);

	//====================
	// Helpers
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check_val(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("mismatch %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic loader_write(input logic [7:0] index, input logic [LD_ADDR_W-1:0] addr,
			input logic [LD_DATA_W-1:0] data);
		@(negedge clk_sys);
		ld_wr    = 1'b1;
		ld_index = index;
		ld_addr  = addr;
		ld_dout  = data;
		@(negedge clk_sys);
		ld_wr = 1'b0;  // One-cycle strobe
	endtask

	task automatic select_game(input logic [7:0] id);
		loader_write(IDX_GAME, '0, {8'h00, id});
		@(negedge clk_sys);  // Flags follow one edge later
	endtask

	task automatic key_event(input logic [8:0] code, input logic pressed);
		@(negedge clk_sys);
		tog     = ~tog;
		ps2_key = {tog, pressed, code};
	endtask

	task automatic set_joy1(input logic [15:0] value);
		@(negedge clk_sys);
		joy1 = value;
	endtask

	// Strobe a column, read once it settles
	task automatic expect_col(input string name, input logic [7:0] col,
			input logic [7:0] expected);
		@(negedge clk_sys);
		col_select = col;
		#1;
		check_val(name, {8'h00, expected}, {8'h00, row_data});
	endtask

	task automatic key_check(input string name, input logic [8:0] code, input logic pressed,
			input logic [7:0] col, input logic [7:0] expected);
		key_event(code, pressed);
		expect_col(name, col, expected);  // One edge after the event
	endtask

	//====================
	// Tests
	task automatic test_reset_select();
		expect_col("reset col1", COL_CT0, 8'hFF);
		expect_col("reset col2", COL_CT1, 8'hFF);
		expect_col("reset col4", COL_CT2, 8'hFF);
		select_game(GAME_SPACEZAP);
		expect_col("spacezap col1", COL_CT0, 8'hF7);  // 11 1 1 0 1 1 1
		select_game(GAME_GORF);
		expect_col("gorf col1", COL_CT0, 8'h3B);      // dip2 bits low
		select_game(GAME_WOW);
		expect_col("wow col1", COL_CT0, 8'h77);
		select_game(GAME_ROBBY);
		expect_col("robby col1", COL_CT0, 8'h77);
		expect_col("robby col 10h", 8'h10, 8'hFF);    // Not a column strobe
		select_game(8'd9);
		expect_col("no game col1", COL_CT0, 8'hFF);
		expect_col("no game col4", COL_CT2, 8'hFF);
	endtask

	task automatic test_keyboard();
		select_game(GAME_SPACEZAP);
		expect_col("sz col4 idle", COL_CT2, 8'hDF);
		key_check("sz up press", KEY_UP, 1'b1, COL_CT2, 8'hDE);
		key_check("sz right e0 press", KEY_RIGHT | 9'h100, 1'b1, COL_CT2, 8'hD6);
		key_check("sz fire press", KEY_FIRE1, 1'b1, COL_CT2, 8'hC6);
		key_check("sz up release", KEY_UP, 1'b0, COL_CT2, 8'hC7);
		key_check("sz down press", KEY_DOWN, 1'b1, COL_CT2, 8'hC5);
		key_check("sz left press", KEY_LEFT, 1'b1, COL_CT2, 8'hC1);
		key_check("sz right release", KEY_RIGHT, 1'b0, COL_CT2, 8'hC9);  // Prefix ignored
		key_check("sz fire release", KEY_FIRE1, 1'b0, COL_CT2, 8'hD9);
		key_check("sz down release", KEY_DOWN, 1'b0, COL_CT2, 8'hDB);
		key_check("sz left release", KEY_LEFT, 1'b0, COL_CT2, 8'hDF);
		// System keys in column 1
		key_check("sz start1 press", KEY_START1, 1'b1, COL_CT0, 8'hE7);
		key_check("sz start1 release", KEY_START1, 1'b0, COL_CT0, 8'hF7);
		key_check("sz f2 press", KEY_START2_F, 1'b1, COL_CT0, 8'hD7);
		key_check("sz f2 release", KEY_START2_F, 1'b0, COL_CT0, 8'hF7);
		key_check("sz coin press", KEY_COIN, 1'b1, COL_CT0, 8'hF5);
		key_check("sz coin release", KEY_COIN, 1'b0, COL_CT0, 8'hF7);
		key_check("sz f3 press", KEY_COIN_F, 1'b1, COL_CT0, 8'hF5);
		key_check("sz f3 release", KEY_COIN_F, 1'b0, COL_CT0, 8'hF7);
	endtask

	task automatic test_joystick();
		select_game(GAME_GORF);
		expect_col("gorf col2 idle", COL_CT1, 8'h3F);  // Top bits 0 0 1
		set_joy1(16'd1 << JOY_UP);
		expect_col("gorf joy up", COL_CT1, 8'h3E);
		key_check("gorf key and joy", KEY_UP2, 1'b1, COL_CT1, 8'h3E);
		set_joy1(16'h0000);
		expect_col("gorf key held", COL_CT1, 8'h3E);
		key_check("gorf key release", KEY_UP2, 1'b0, COL_CT1, 8'h3F);
		set_joy1((16'd1 << JOY_RIGHT) | (16'd1 << JOY_FIRE));
		expect_col("gorf joy right fire", COL_CT1, 8'h27);
		set_joy1((16'd1 << JOY_LEFT) | (16'd1 << JOY_DOWN));
		expect_col("gorf joy left down", COL_CT1, 8'h39);
		set_joy1(16'h0000);
		@(negedge clk_sys);
		joy0 = 16'd1 << JOY_FIRE;  // Player 1 side
		expect_col("gorf joy0 fire", COL_CT2, 8'h2F);
		@(negedge clk_sys);
		joy0 = 16'h0000;
	endtask

	task automatic test_dip();
		loader_write(IDX_DIP, 25'd2, 16'h5A05);  // High byte dropped
		expect_col("dip2 05 gorf col1", COL_CT0, 8'hFB);
		loader_write(IDX_DIP, 25'd3, 16'h00A5);
		expect_col("dip3 col8", COL_CT3, 8'hA5);
		loader_write(8'd3, 25'd2, 16'h00FF);     // Wrong index
		expect_col("wrong index col1", COL_CT0, 8'hFB);
		expect_col("wrong index col8", COL_CT3, 8'hA5);
		loader_write(IDX_DIP, 25'd2, 16'h0002);
		expect_col("dip2 02 gorf col1", COL_CT0, 8'h3F);
		select_game(GAME_SPACEZAP);
		expect_col("dip2 02 sz col1", COL_CT0, 8'hFF);
		expect_col("dip2 02 sz col4", COL_CT2, 8'hDF);
		expect_col("sz col8", COL_CT3, 8'hA5);
		loader_write(IDX_DIP, 25'd2, 16'h0001);
		expect_col("dip2 01 sz col1", COL_CT0, 8'hF7);
		expect_col("dip2 01 sz col4", COL_CT2, 8'hFF);
		loader_write(IDX_DIP, 25'd2, 16'h0000);
	endtask

	task automatic test_wow_robby();
		select_game(GAME_WOW);
		expect_col("wow col4 idle", COL_CT2, 8'h6F);
		@(negedge clk_sys);
		speech_busy = 1'b1;
		expect_col("wow busy", COL_CT2, 8'hEF);
		key_check("wow fire b", KEY_FIRE2, 1'b1, COL_CT2, 8'hFF);  // Active high
		key_check("wow fire a", KEY_FIRE1, 1'b1, COL_CT2, 8'hDF);
		key_event(KEY_FIRE2, 1'b0);
		key_check("wow fires off", KEY_FIRE1, 1'b0, COL_CT2, 8'hEF);
		expect_col("wow col2 idle", COL_CT1, 8'hEF);
		set_joy1(16'd1 << JOY_FIRE_B);
		expect_col("wow joy fire b", COL_CT1, 8'hFF);
		set_joy1(16'h0000);
		// Robby ignores busy and fire B
		select_game(GAME_ROBBY);
		expect_col("robby busy", COL_CT2, 8'hFF);
		key_check("robby fire b", KEY_FIRE2, 1'b1, COL_CT2, 8'hFF);
		key_check("robby fire a", KEY_FIRE1, 1'b1, COL_CT2, 8'hDF);
		key_event(KEY_FIRE2, 1'b0);
		key_check("robby fires off", KEY_FIRE1, 1'b0, COL_CT2, 8'hFF);
		@(negedge clk_sys);
		speech_busy = 1'b0;
	endtask

	task automatic test_audio();
		logic [AUD_W-1:0] exp_l;
		logic [AUD_W-1:0] exp_r;
		for (int g = 2; g <= 6; g++) begin  // Id 2 has no game
			select_game(g[7:0]);
			repeat (8) begin
				@(negedge clk_sys);
				rng    = xorshift(rng);
				snd_l  = rng[7:0];
				snd_r  = rng[15:8];
				samp_l = rng[31:16];
				rng    = xorshift(rng);
				samp_r = rng[15:0];
				if (g == GAME_GORF) begin
					// Byte on bits 14:7, its top seven bits below
					exp_l = {8'h00, snd_l} * 16'd128 + {8'h00, snd_l} / 16'd2 +
						(samp_l >> SAMPLE_SHIFT);
					exp_r = {8'h00, snd_r} * 16'd128 + {8'h00, snd_r} / 16'd2 +
						(samp_r >> SAMPLE_SHIFT);
				end else if (g == GAME_WOW || g == GAME_ROBBY) begin
					exp_l = {snd_l, snd_l};
					exp_r = {snd_r, snd_r};
				end else begin
					exp_l = {snd_l, snd_l};  // Left on both
					exp_r = {snd_l, snd_l};
				end
				@(negedge clk_sys);  // One edge of latency
				check_val($sformatf("audio game %0d left", g), exp_l, audio_l);
				check_val($sformatf("audio game %0d right", g), exp_r, audio_r);
			end
		end
	endtask

	//====================
	// Sequence
	initial begin
		errors      = 0;
		checks      = 0;
		tog         = 1'b0;
		rng         = 32'had2f;
		ld_wr       = 1'b0;
		ld_index    = 8'h00;
		ld_addr     = '0;
		ld_dout     = '0;
		ps2_key     = 11'h000;
		joy0        = 16'h0000;
		joy1        = 16'h0000;
		col_select  = 8'h00;
		speech_busy = 1'b0;
		snd_l       = '0;
		snd_r       = '0;
		samp_l      = '0;
		samp_r      = '0;
		@(negedge reset);
		@(posedge clk_sys);
		test_reset_select();
		test_keyboard();
		test_joystick();
		test_dip();
		test_wow_robby();
		test_audio();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	// Watchdog
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == TIMEOUT_CYCLES) begin
			$display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("checks %0d, errors %0d", checks, errors);
			$display("TESTS FAILED");
			$finish;
		end
	end

endmodule

/* filelist.f */
rtl/astro_sys_pkg.sv
rtl/astro_input_pkg.sv
rtl/game_config.sv
rtl/player_controls.sv
rtl/switch_matrix.sv
rtl/audio_mixer.sv
rtl/astro_io_top.sv
dv/tb_clock.sv
dv/tb_astro_io.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_astro_io \
	-f filelist.f -o sim_tb > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -qx "TESTS PASSED" sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see sim.log"; exit 1; }
